// File: src/spectral_pkg.sv
// Spectral threshold detector shared definitions.
// Sizes of one spectrum frame and the vector types used across the design.

package spectral_pkg;

  // ####################
  // Frame geometry
  // ####################

  localparam int N_BINS      = 8;  // Spectrum bins in one frame.
  localparam int LOG2_N_BINS = 3;  // Shift amount that divides by N_BINS.

  // ####################
  // Data widths
  // ####################

  localparam int SAMPLE_W = 16;  // One signed real or imaginary part.
  // A magnitude needs one extra bit so that |-2^15| and the half-min term fit.
  localparam int MAG_W    = SAMPLE_W + 1;
  localparam int FREQ_W   = 16;  // Frequencies are in hertz units.

  // ####################
  // Vector types
  // ####################

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // Real or imaginary part.
  typedef logic        [MAG_W-1:0]    mag_t;     // Bin magnitude or threshold.
  typedef logic        [FREQ_W-1:0]   freq_t;    // Sampling, cutoff or bin frequency.

endpackage

// File: src/classifier_cfg_regs.sv
// Configuration registers of the spectral threshold detector.
// Each value loads on its valid strobe and clears to zero on reset.

module classifier_cfg_regs
  import spectral_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  input  logic  cutoff_freq_val,
  input  freq_t cutoff_freq_msg,
  input  logic  cutoff_mag_val,
  input  mag_t  cutoff_mag_msg,
  input  logic  sampling_freq_val,
  input  freq_t sampling_freq_msg,

  output freq_t cutoff_freq,
  output mag_t  cutoff_mag,
  output freq_t sampling_freq
);

  // A frame in the same cycle as a write still sees the old value.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cutoff_freq <= '0;  // Zero cutoff lets every bin through.
    end else if (cutoff_freq_val) begin
      cutoff_freq <= cutoff_freq_msg;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cutoff_mag <= '0;  // Zero threshold detects any nonzero bin.
    end else if (cutoff_mag_val) begin
      cutoff_mag <= cutoff_mag_msg;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sampling_freq <= '0;
    end else if (sampling_freq_val) begin
      sampling_freq <= sampling_freq_msg;
    end
  end

endmodule

// File: src/bin_magnitude.sv
// Per-bin magnitude estimate of a complex spectrum frame.
// Uses max(|re|,|im|) + min(|re|,|im|)/2, which stays within about 12% of the modulus.

module bin_magnitude
  import spectral_pkg::*;
(
  input  sample_t re      [N_BINS],
  input  sample_t im      [N_BINS],
  output mag_t    bin_mag [N_BINS]
);

  // Absolute value widened by one bit, so the most negative sample is safe.
  function automatic mag_t abs_wide(input sample_t s);
    logic signed [MAG_W-1:0] wide;
    wide = s;  // Sign extension to MAG_W bits.
    if (wide[MAG_W-1]) begin
      return mag_t'(-wide);
    end
    return mag_t'(wide);
  endfunction

  // ####################
  // Per-bin estimate
  // ####################

  for (genvar k = 0; k < N_BINS; k++) begin : g_bin
    mag_t abs_re;
    mag_t abs_im;
    mag_t big;
    mag_t smaller;

    assign abs_re = abs_wide(re[k]);
    assign abs_im = abs_wide(im[k]);

    assign big     = (abs_re >= abs_im) ? abs_re : abs_im;  // Larger component.
    assign smaller = (abs_re >= abs_im) ? abs_im : abs_re;  // Smaller component.

    // Half-min rounds down; the sum stays below 2^MAG_W.
    assign bin_mag[k] = big + (smaller >> 1);
  end

endmodule

// File: src/bin_highpass_mask.sv
// High-pass mask over the spectrum bins.
// Bin k sits at k * fs / N_BINS and passes when it is at or above the cutoff.

module bin_highpass_mask
  import spectral_pkg::*;
(
  input  freq_t sampling_freq,
  input  freq_t cutoff_freq,
  output logic  bin_pass [N_BINS]
);

  // The product carries LOG2_N_BINS extra bits, because k is below N_BINS.
  logic [FREQ_W+LOG2_N_BINS-1:0] bin_prod [N_BINS];
  freq_t                         bin_freq [N_BINS];

  // ####################
  // Bin frequencies
  // ####################

  for (genvar k = 0; k < N_BINS; k++) begin : g_bin
    // Evaluated at the full product width, so nothing overflows.
    assign bin_prod[k] = LOG2_N_BINS'(k) * sampling_freq;

    // Division by N_BINS rounds down, and the result fits in FREQ_W bits.
    assign bin_freq[k] = freq_t'(bin_prod[k] >> LOG2_N_BINS);

    // A bin exactly on the cutoff is kept.
    assign bin_pass[k] = (bin_freq[k] >= cutoff_freq);
  end

endmodule

// File: src/threshold_detector.sv
// Detection comparator of the spectral threshold detector.
// Flags a frame when any unmasked bin magnitude exceeds the threshold.

module threshold_detector
  import spectral_pkg::*;
(
  input  mag_t bin_mag  [N_BINS],
  input  logic bin_pass [N_BINS],
  input  mag_t cutoff_mag,
  output logic detect
);

  logic [N_BINS-1:0] bin_hit;  // One flag per bin above the threshold.

  // ####################
  // Per-bin compare
  // ####################

  for (genvar k = 0; k < N_BINS; k++) begin : g_bin
    // Strictly greater, so a magnitude equal to the threshold does not count.
    assign bin_hit[k] = bin_pass[k] && (bin_mag[k] > cutoff_mag);
  end

  assign detect = |bin_hit;  // Any hit in the frame raises the detection.

endmodule

// File: src/spectral_classifier.sv
// Spectral threshold detector, top level.
// One combinational frame path with registered cutoff and sampling settings.

module spectral_classifier
  import spectral_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,

  output logic    recv_rdy,
  input  logic    recv_val,
  input  sample_t recv_re [N_BINS],
  input  sample_t recv_im [N_BINS],

  output logic    cutoff_freq_rdy,
  input  logic    cutoff_freq_val,
  input  freq_t   cutoff_freq_msg,

  output logic    cutoff_mag_rdy,
  input  logic    cutoff_mag_val,
  input  mag_t    cutoff_mag_msg,

  output logic    sampling_freq_rdy,
  input  logic    sampling_freq_val,
  input  freq_t   sampling_freq_msg,

  input  logic    send_rdy,
  output logic    send_val,
  output logic    send_msg
);

  freq_t cutoff_freq;
  mag_t  cutoff_mag;
  freq_t sampling_freq;
  mag_t  bin_mag  [N_BINS];
  logic  bin_pass [N_BINS];
  logic  detect;

  // ####################
  // Configuration
  // ####################

  classifier_cfg_regs u_cfg_regs (
    .clk               (clk),
    .arst_n            (arst_n),
    .cutoff_freq_val   (cutoff_freq_val),
    .cutoff_freq_msg   (cutoff_freq_msg),
    .cutoff_mag_val    (cutoff_mag_val),
    .cutoff_mag_msg    (cutoff_mag_msg),
    .sampling_freq_val (sampling_freq_val),
    .sampling_freq_msg (sampling_freq_msg),
    .cutoff_freq       (cutoff_freq),
    .cutoff_mag        (cutoff_mag),
    .sampling_freq     (sampling_freq)
  );

  // Registers accept a write in any cycle.
  assign cutoff_freq_rdy   = 1'b1;
  assign cutoff_mag_rdy    = 1'b1;
  assign sampling_freq_rdy = 1'b1;

  // ####################
  // Frame path
  // ####################

  bin_magnitude u_magnitude (
    .re      (recv_re),
    .im      (recv_im),
    .bin_mag (bin_mag)
  );

  bin_highpass_mask u_highpass (
    .sampling_freq (sampling_freq),
    .cutoff_freq   (cutoff_freq),
    .bin_pass      (bin_pass)
  );

  threshold_detector u_detector (
    .bin_mag    (bin_mag),
    .bin_pass   (bin_pass),
    .cutoff_mag (cutoff_mag),
    .detect     (detect)
  );

  // Nothing is stored, so frame and result move in the same cycle.
  assign send_msg = detect;
  assign send_val = recv_val;
  assign recv_rdy = send_rdy;  // Back-pressure goes straight to the source.

endmodule

// File: test/spectral_classifier_asserts.sv
// Handshake checks for the spectral threshold detector.
// Bound to the top level and sampled on the rising clock edge.

module spectral_classifier_asserts (
  input logic clk,
  input logic arst_n,
  input logic recv_val,
  input logic recv_rdy,
  input logic send_val,
  input logic send_rdy,
  input logic send_msg,
  input logic cutoff_freq_rdy,
  input logic cutoff_mag_rdy,
  input logic sampling_freq_rdy
);

  // The frame path is combinational, so both handshakes line up.
  a_send_val: assert property (@(posedge clk) disable iff (!arst_n) send_val == recv_val)
    else $error("send_val does not follow recv_val");

  a_recv_rdy: assert property (@(posedge clk) disable iff (!arst_n) recv_rdy == send_rdy)
    else $error("recv_rdy does not follow send_rdy");

  a_cfg_rdy: assert property (@(posedge clk) disable iff (!arst_n)
                              cutoff_freq_rdy && cutoff_mag_rdy && sampling_freq_rdy)
    else $error("a configuration ready output went low");

  a_msg_known: assert property (@(posedge clk) disable iff (!arst_n)
                                send_val |-> !$isunknown(send_msg))
    else $error("send_msg is unknown while send_val is high");

endmodule

bind spectral_classifier spectral_classifier_asserts u_asserts (
  .clk (clk), .arst_n (arst_n),
  .recv_val (recv_val), .recv_rdy (recv_rdy),
  .send_val (send_val), .send_rdy (send_rdy), .send_msg (send_msg),
  .cutoff_freq_rdy (cutoff_freq_rdy), .cutoff_mag_rdy (cutoff_mag_rdy),
  .sampling_freq_rdy (sampling_freq_rdy)
);

// File: test/tb_spectral_classifier.sv
// Testbench for the spectral threshold detector.
// Drives random and directed frames and checks send_msg against a model.

module tb_spectral_classifier
  import spectral_pkg::*;
();

  localparam int          MAX_CYCLES = 2000;          // Tests need about 350 cycles.
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1.

  logic    clk;
  logic    arst_n;
  logic    recv_rdy;
  logic    recv_val;
  sample_t recv_re [N_BINS];
  sample_t recv_im [N_BINS];
  logic    cutoff_freq_rdy;
  logic    cutoff_freq_val;
  freq_t   cutoff_freq_msg;
  logic    cutoff_mag_rdy;
  logic    cutoff_mag_val;
  mag_t    cutoff_mag_msg;
  logic    sampling_freq_rdy;
  logic    sampling_freq_val;
  freq_t   sampling_freq_msg;
  logic    send_rdy;
  logic    send_val;
  logic    send_msg;

  logic [31:0] lfsr_state;
  freq_t       m_cutoff_freq;    // Model copy of the configuration registers.
  mag_t        m_cutoff_mag;
  freq_t       m_sampling_freq;
  logic        sampled_msg;
  logic        held;
  logic        held_msg;
  int          bin_idx;
  int          cycle_count;
  int          check_count;
  int          fail_count;
  int          start_checks;
  int          start_fails;

  spectral_classifier uut (
    .clk (clk), .arst_n (arst_n),
    .recv_rdy (recv_rdy), .recv_val (recv_val), .recv_re (recv_re), .recv_im (recv_im),
    .cutoff_freq_rdy (cutoff_freq_rdy), .cutoff_freq_val (cutoff_freq_val),
    .cutoff_freq_msg (cutoff_freq_msg),
    .cutoff_mag_rdy (cutoff_mag_rdy), .cutoff_mag_val (cutoff_mag_val),
    .cutoff_mag_msg (cutoff_mag_msg),
    .sampling_freq_rdy (sampling_freq_rdy), .sampling_freq_val (sampling_freq_val),
    .sampling_freq_msg (sampling_freq_msg),
    .send_rdy (send_rdy), .send_val (send_val), .send_msg (send_msg)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("TIMEOUT: run stopped after %0d cycles without finishing", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ####################
  // Stimulus and model
  // ####################

  // Galois LFSR that steps once for each bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  // Larger modulus part plus half the smaller one, rounded down.
  function automatic mag_t model_mag(input sample_t re, input sample_t im);
    int a;
    int b;
    a = re;
    b = im;
    a = (a < 0) ? -a : a;
    b = (b < 0) ? -b : b;
    return (a >= b) ? mag_t'(a + b / 2) : mag_t'(b + a / 2);
  endfunction

  function automatic logic model_detect();
    int   bin_f;
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < N_BINS; k++) begin
      bin_f = (k * int'(m_sampling_freq)) / N_BINS;  // Bin centre frequency.
      if (bin_f >= int'(m_cutoff_freq) && model_mag(recv_re[k], recv_im[k]) > m_cutoff_mag)
        hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic clear_frame();
    for (int k = 0; k < N_BINS; k++) begin
      recv_re[k] = '0;
      recv_im[k] = '0;
    end
  endtask

  task automatic randomize_frame();
    for (int k = 0; k < N_BINS; k++) begin
      recv_re[k] = sample_t'(rand_bits(16));
      recv_im[k] = sample_t'(rand_bits(16));
      if (rand_bits(3) == 32'd0) recv_re[k] = 16'sh8000;  // Most negative sample.
      if (rand_bits(4) == 32'd1) recv_im[k] = 16'sh8000;
    end
  endtask

  // ####################
  // Checks and report
  // ####################

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    check_count++;
    assert (actual === expected) else begin
      fail_count++;
      $display("FAILED %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  // Samples just before the edge, then moves the model registers with the DUT.
  task automatic run_cycle(input int want);
    #33;
    sampled_msg = send_msg;
    compare_bit("send_val", recv_val, send_val);
    compare_bit("recv_rdy", send_rdy, recv_rdy);
    compare_bit("cutoff_freq_rdy", 1'b1, cutoff_freq_rdy);
    compare_bit("cutoff_mag_rdy", 1'b1, cutoff_mag_rdy);
    compare_bit("sampling_freq_rdy", 1'b1, sampling_freq_rdy);
    if (recv_val) begin
      compare_bit("send_msg", model_detect(), send_msg);
      if (want >= 0) compare_bit("send_msg", want[0], send_msg);
    end
    if (cutoff_freq_val) m_cutoff_freq = cutoff_freq_msg;
    if (cutoff_mag_val) m_cutoff_mag = cutoff_mag_msg;
    if (sampling_freq_val) m_sampling_freq = sampling_freq_msg;
    @(posedge clk);
    #5;  // Inputs change a little after the edge.
  endtask

  task automatic start_test();
    start_checks = check_count;
    start_fails  = fail_count;
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d checks, %0d failures", name,
             check_count - start_checks, fail_count - start_fails);
  endtask

  initial begin
    lfsr_state = 32'hbfc5;
    arst_n = 1'b0;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    cutoff_freq_val = 1'b0;
    cutoff_freq_msg = '0;
    cutoff_mag_val = 1'b0;
    cutoff_mag_msg = '0;
    sampling_freq_val = 1'b0;
    sampling_freq_msg = '0;
    clear_frame();
    m_cutoff_freq = '0;
    m_cutoff_mag = '0;
    m_sampling_freq = '0;
    held = 1'b0;
    held_msg = 1'b0;
    cycle_count = 0;
    check_count = 0;
    fail_count = 0;
    repeat (4) @(posedge clk);
    #5;
    arst_n = 1'b1;

    start_test();  // Zero cutoff and threshold after reset.
    recv_val = 1'b1;
    send_rdy = 1'b1;
    bin_idx = int'(rand_bits(3));
    recv_im[bin_idx] = 16'sd1;
    run_cycle(1);
    clear_frame();
    run_cycle(0);
    report_test("reset_defaults");

    start_test();
    for (int i = 0; i < 200; i++) begin
      recv_val = (rand_bits(2) != 32'd0);
      cutoff_freq_val = (rand_bits(3) == 32'd0);
      cutoff_freq_msg = freq_t'(rand_bits(16));
      cutoff_mag_val = (rand_bits(3) == 32'd0);
      cutoff_mag_msg = mag_t'(rand_bits(16));
      sampling_freq_val = (rand_bits(3) == 32'd0);
      sampling_freq_msg = freq_t'(rand_bits(16));
      randomize_frame();
      run_cycle(-1);
    end
    report_test("random_config");

    start_test();  // Bins sit at k * 1000, so bins 3 to 7 pass.
    recv_val = 1'b0;
    cutoff_freq_val = 1'b1;
    cutoff_freq_msg = 16'd3000;
    cutoff_mag_val = 1'b1;
    cutoff_mag_msg = 17'd100;
    sampling_freq_val = 1'b1;
    sampling_freq_msg = 16'd8000;
    run_cycle(-1);
    cutoff_freq_val = 1'b0;
    cutoff_mag_val = 1'b0;
    sampling_freq_val = 1'b0;
    recv_val = 1'b1;
    clear_frame();
    for (int k = 0; k < 3; k++) recv_re[k] = 16'sd20000;
    run_cycle(0);
    clear_frame();
    recv_re[3] = 16'sd20000;
    run_cycle(1);
    cutoff_freq_val = 1'b1;
    cutoff_freq_msg = 16'd3001;
    run_cycle(1);  // Write cycle still uses the old cutoff.
    cutoff_freq_val = 1'b0;
    run_cycle(0);
    report_test("highpass_mask");

    start_test();  // Bin 4 estimate is 300 + 100/2 = 350.
    clear_frame();
    recv_re[4] = 16'sd300;
    recv_im[4] = -16'sd100;
    cutoff_mag_val = 1'b1;
    cutoff_mag_msg = 17'd350;
    run_cycle(1);
    cutoff_mag_val = 1'b0;
    run_cycle(0);
    recv_re[4] = 16'sd301;
    run_cycle(1);
    report_test("magnitude_edge");

    start_test();
    for (int i = 0; i < 100; i++) begin
      send_rdy = (rand_bits(1) != 32'd0);
      if (!held) begin
        recv_val = (rand_bits(1) != 32'd0);
        randomize_frame();
      end
      run_cycle(-1);
      if (held) compare_bit("send_msg", held_msg, sampled_msg);
      held_msg = sampled_msg;
      held = recv_val && !send_rdy;  // The source keeps a frame that was not taken.
    end
    recv_val = 1'b0;
    report_test("handshake");

    $display("checks: %0d passed, %0d failed", check_count - fail_count, fail_count);
    if (fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sources.f
src/spectral_pkg.sv
src/classifier_cfg_regs.sv
src/bin_magnitude.sv
src/bin_highpass_mask.sv
src/threshold_detector.sv
src/spectral_classifier.sv
test/spectral_classifier_asserts.sv
test/tb_spectral_classifier.sv

// File: run_sim.sh
#!/bin/sh
# Builds the spectral classifier testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_spectral_classifier \
  -f sources.f \
  --Mdir obj_dir

# The result is taken from the log, so a stopped simulation does not end the script here.
./obj_dir/Vtb_spectral_classifier > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
